// ==== mcu_ctrl_pkg.sv ====
package mcu_ctrl_pkg;

  // Job sequencer states, as seen by the BRAM walker
  typedef enum logic [2:0] {
    GLO_IDLE = 3'd0,
    GLO_STR  = 3'd1,
    GLO_RUN  = 3'd2,
    GLO_END  = 3'd3,
    GLO_ERR  = 3'd4
  } glo_state_t;

  // BRAM walker states
  typedef enum logic [1:0] {
    LOC_STR = 2'd0,
    LOC_OPE = 2'd1,
    LOC_END = 2'd3,
    LOC_ERR = 2'd2
  } loc_state_t;

  localparam int LIMIT_WIDTH = 16;

  // Job limits, each one a plain count
  typedef struct packed {
    logic [LIMIT_WIDTH-1:0] addr_max;
    logic [LIMIT_WIDTH-1:0] inter_max;
    logic [LIMIT_WIDTH-1:0] intra_max;
  } mcu_limits_t;

endpackage

// ==== mcu_stream_pkg.sv ====
package mcu_stream_pkg;

  localparam int DATA_WIDTH = 16;

  // One stream transfer
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } stream_beat_t;

  // BRAM load port, upper address bits beyond the depth are dropped
  typedef struct packed {
    logic                  en;
    logic [15:0]           addr;
    logic [DATA_WIDTH-1:0] data;
  } bram_wr_t;

endpackage

// ==== data_bram.sv ====
module data_bram #(
  parameter int ADDR_WIDTH = 6,
  parameter bit BRAM_ACK   = 1'b1
) (
  input  logic                                 clk,
  input  mcu_stream_pkg::bram_wr_t             wr,
  input  logic                                 rd_en,
  input  logic [ADDR_WIDTH-1:0]                rd_addr,
  output logic [mcu_stream_pkg::DATA_WIDTH-1:0] rd_data,
  output logic                                 rd_ack
);
  import mcu_stream_pkg::*;

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // Write port from the loader, registered read port for the walker
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr[ADDR_WIDTH-1:0]] <= wr.data;
    end
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  generate
    if (BRAM_ACK) begin : g_ack
      // Ack lines up with the registered read data
      always_ff @(posedge clk) begin
        rd_ack <= rd_en;
      end
    end else begin : g_no_ack
      assign rd_ack = 1'b0;
    end
  endgenerate

endmodule

// ==== axis_skid_buffer.sv ====
module axis_skid_buffer (
  input  logic                         clk,
  input  logic                         rst,
  input  mcu_stream_pkg::stream_beat_t in_beat,
  input  logic                         in_valid,
  output logic                         in_ready,
  output mcu_stream_pkg::stream_beat_t out_beat,
  output logic                         out_valid,
  input  logic                         out_ready
);
  import mcu_stream_pkg::*;

  stream_beat_t main_beat;
  stream_beat_t spare_beat;
  logic         main_valid;
  logic         spare_valid;
  logic         main_valid_next;
  logic         spare_valid_next;
  logic         accept;
  logic         pop;

  assign accept = in_valid && in_ready;

  // Empty buffer passes the input straight through
  assign out_valid = main_valid || accept;
  assign out_beat  = main_valid ? main_beat : in_beat;
  assign pop       = out_valid && out_ready;

  always_comb begin
    if (main_valid) begin
      main_valid_next  = !pop || spare_valid || accept;
      spare_valid_next = pop ? (spare_valid && accept) : (spare_valid || accept);
    end else begin
      main_valid_next  = accept && !pop;
      spare_valid_next = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid  <= 1'b0;
      spare_valid <= 1'b0;
      in_ready    <= 1'b0;
    end else begin
      main_valid  <= main_valid_next;
      spare_valid <= spare_valid_next;
      // Ready drops only once the spare entry is taken
      in_ready    <= !spare_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (main_valid ? pop : accept) begin
      main_beat <= (main_valid && spare_valid) ? spare_beat : in_beat;
    end
    if (main_valid && accept) begin
      spare_beat <= in_beat;
    end
  end

endmodule

// ==== mcu_global_fsm.sv ====
module mcu_global_fsm (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  mcu_ctrl_pkg::mcu_limits_t limits,
  input  logic                      tlast_sent,
  input  logic                      loc_error,
  output mcu_ctrl_pkg::glo_state_t  glo_state,
  output mcu_ctrl_pkg::mcu_limits_t job_limits,
  output logic                      done,
  output logic                      error,
  output logic                      busy
);
  import mcu_ctrl_pkg::*;

  glo_state_t state_next;
  logic       str_wait;

  always_comb begin
    state_next = glo_state;
    case (glo_state)
      GLO_IDLE: begin
        if (start) begin
          state_next = GLO_STR;
        end
      end
      // Second start cycle, local FSM has answered by now
      GLO_STR: begin
        if (loc_error) begin
          state_next = GLO_ERR;
        end else if (str_wait) begin
          state_next = GLO_RUN;
        end
      end
      GLO_RUN: begin
        if (tlast_sent) begin
          state_next = GLO_END;
        end
      end
      GLO_END: state_next = GLO_IDLE;
      GLO_ERR: state_next = GLO_IDLE;
      default: state_next = GLO_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      glo_state <= GLO_IDLE;
      str_wait  <= 1'b0;
    end else begin
      glo_state <= state_next;
      str_wait  <= (glo_state == GLO_STR) && !str_wait;
    end
  end

  // Limits held for the whole job
  always_ff @(posedge clk) begin
    if (glo_state == GLO_IDLE && start) begin
      job_limits <= limits;
    end
  end

  assign done  = glo_state == GLO_END;
  assign error = glo_state == GLO_ERR;
  assign busy  = glo_state != GLO_IDLE;

endmodule

// ==== mcu_local_bram_fsm.sv ====
module mcu_local_bram_fsm #(
  parameter int ADDR_WIDTH = 6,
  parameter bit BRAM_ACK   = 1'b1
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  mcu_ctrl_pkg::glo_state_t              glo_state,
  input  mcu_ctrl_pkg::mcu_limits_t             job_limits,
  output logic                                  rd_en,
  output logic [ADDR_WIDTH-1:0]                 rd_addr,
  input  logic [mcu_stream_pkg::DATA_WIDTH-1:0] rd_data,
  input  logic                                  rd_ack,
  output mcu_stream_pkg::stream_beat_t          in_beat,
  output logic                                  in_valid,
  input  logic                                  in_ready,
  input  mcu_stream_pkg::stream_beat_t          mid_beat,
  input  logic                                  mid_valid,
  output logic                                  mid_ready,
  output mcu_stream_pkg::stream_beat_t          out_beat,
  output logic                                  out_valid,
  input  logic                                  out_ready,
  output logic                                  tlast_sent,
  output logic                                  loc_error
);
  import mcu_ctrl_pkg::*;

  loc_state_t             state;
  loc_state_t             state_next;
  mcu_limits_t            last_idx;
  logic [ADDR_WIDTH-1:0]  addr_cnt;
  logic [LIMIT_WIDTH-1:0] inter_cnt;
  logic [LIMIT_WIDTH-1:0] intra_cnt;
  logic                   zero_limit;
  logic                   start_job;
  logic                   addr_wrap;
  logic                   pass_done;
  logic                   ack_int;
  logic                   ack_pend;
  logic                   final_rep;
  logic                   beat_xfer;

  assign zero_limit = (job_limits.addr_max == '0) || (job_limits.inter_max == '0) ||
                      (job_limits.intra_max == '0);
  assign start_job  = (state == LOC_STR) && (glo_state == GLO_STR);

  // Reads only go out while the skid buffer can take the word
  assign rd_en     = (state == LOC_OPE) && in_ready;
  assign rd_addr   = addr_cnt;
  assign addr_wrap = LIMIT_WIDTH'(addr_cnt) == last_idx.addr_max;
  assign pass_done = rd_en && addr_wrap && (inter_cnt == last_idx.inter_max);

  always_comb begin
    state_next = state;
    case (state)
      LOC_STR: begin
        if (glo_state == GLO_STR) begin
          state_next = zero_limit ? LOC_ERR : LOC_OPE;
        end
      end
      LOC_OPE: begin
        if (pass_done) begin
          state_next = LOC_END;
        end
      end
      LOC_END: begin
        if (glo_state == GLO_END) begin
          state_next = LOC_STR;
        end
      end
      LOC_ERR: begin
        if (glo_state == GLO_ERR) begin
          state_next = LOC_STR;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= LOC_STR;
      addr_cnt  <= '0;
      inter_cnt <= '0;
    end else begin
      state <= state_next;
      if (start_job) begin
        addr_cnt  <= '0;
        inter_cnt <= '0;
      end else if (rd_en) begin
        if (addr_wrap) begin
          addr_cnt  <= '0;
          inter_cnt <= inter_cnt + 1'b1;
        end else begin
          addr_cnt <= addr_cnt + 1'b1;
        end
      end
    end
  end

  // Limits kept as last index so compares are plain equality
  always_ff @(posedge clk) begin
    if (start_job) begin
      last_idx.addr_max  <= job_limits.addr_max - 1'b1;
      last_idx.inter_max <= job_limits.inter_max - 1'b1;
      last_idx.intra_max <= job_limits.intra_max - 1'b1;
    end
  end

  generate
    if (BRAM_ACK) begin : g_bram_ack
      assign ack_int = rd_ack;
    end else begin : g_fixed_latency
      logic rd_en_q;

      // Data is assumed one cycle behind the read strobe
      always_ff @(posedge clk) begin
        if (rst) begin
          rd_en_q <= 1'b0;
        end else begin
          rd_en_q <= rd_en;
        end
      end
      assign ack_int = rd_en_q;
    end
  endgenerate

  // Read data stays on the BRAM register until the skid buffer takes it
  assign in_valid     = ack_int || ack_pend;
  assign in_beat.data = rd_data;
  assign in_beat.last = state == LOC_END;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_pend <= 1'b0;
    end else begin
      ack_pend <= in_valid && !in_ready;
    end
  end

  // Hold each skid word until it has gone out intra_max times
  assign final_rep     = intra_cnt == last_idx.intra_max;
  assign beat_xfer     = mid_valid && out_ready;
  assign mid_ready     = out_ready && final_rep;
  assign out_valid     = mid_valid;
  assign out_beat.data = mid_beat.data;
  assign out_beat.last = mid_beat.last && final_rep;

  always_ff @(posedge clk) begin
    if (rst) begin
      intra_cnt  <= '0;
      tlast_sent <= 1'b0;
    end else begin
      tlast_sent <= beat_xfer && out_beat.last;
      if (state == LOC_STR) begin
        intra_cnt <= '0;
      end else if (beat_xfer) begin
        intra_cnt <= final_rep ? '0 : intra_cnt + 1'b1;
      end
    end
  end

  assign loc_error = state == LOC_ERR;

endmodule

// ==== mcu_stream_top.sv ====
module mcu_stream_top #(
  parameter int ADDR_WIDTH = 6,
  parameter bit BRAM_ACK   = 1'b1
) (
  input  logic                         clk,
  input  logic                         rst,
  input  mcu_stream_pkg::bram_wr_t     wr,
  input  logic                         start,
  input  mcu_ctrl_pkg::mcu_limits_t    limits,
  output mcu_stream_pkg::stream_beat_t out_beat,
  output logic                         out_valid,
  input  logic                         out_ready,
  output logic                         done,
  output logic                         error,
  output logic                         busy
);
  import mcu_ctrl_pkg::*;
  import mcu_stream_pkg::*;

  glo_state_t            glo_state;
  mcu_limits_t           job_limits;
  logic                  tlast_sent;
  logic                  loc_error;
  logic                  rd_en;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  rd_ack;
  stream_beat_t          in_beat;
  logic                  in_valid;
  logic                  in_ready;
  stream_beat_t          mid_beat;
  logic                  mid_valid;
  logic                  mid_ready;

  mcu_global_fsm u_global_fsm (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .limits     (limits),
    .tlast_sent (tlast_sent),
    .loc_error  (loc_error),
    .glo_state  (glo_state),
    .job_limits (job_limits),
    .done       (done),
    .error      (error),
    .busy       (busy)
  );

  mcu_local_bram_fsm #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .BRAM_ACK   (BRAM_ACK)
  ) u_local_fsm (
    .clk        (clk),
    .rst        (rst),
    .glo_state  (glo_state),
    .job_limits (job_limits),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .rd_ack     (rd_ack),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .mid_beat   (mid_beat),
    .mid_valid  (mid_valid),
    .mid_ready  (mid_ready),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .tlast_sent (tlast_sent),
    .loc_error  (loc_error)
  );

  data_bram #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .BRAM_ACK   (BRAM_ACK)
  ) u_bram (
    .clk     (clk),
    .wr      (wr),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rd_ack  (rd_ack)
  );

  axis_skid_buffer u_skid (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (mid_beat),
    .out_valid (mid_valid),
    .out_ready (mid_ready)
  );

endmodule

// ==== mcu_stream_sva.sv ====
module mcu_stream_sva (
  input logic                         clk,
  input logic                         rst,
  input mcu_stream_pkg::stream_beat_t out_beat,
  input logic                         out_valid,
  input logic                         out_ready,
  input logic                         done,
  input logic                         error,
  input logic                         busy
);
  timeunit 1ns;
  timeprecision 1ps;

  // Number of assertion failures so far
  int fail_count = 0;

  // A stalled beat stays on the port unchanged
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
  else begin
    $error("out_beat or out_valid changed while out_ready was low");
    fail_count++;
  end

  // Done comes alone and two cycles after the final transfer
  a_done_error: assert property (@(posedge clk) disable iff (rst)
    done |-> !error && $past(out_valid && out_ready && out_beat.last, 2))
  else begin
    $error("done high together with error or not two cycles after the final beat");
    fail_count++;
  end

  a_idle_quiet: assert property (@(posedge clk) disable iff (rst) !busy |-> !out_valid)
  else begin
    $error("out_valid high while the engine is idle");
    fail_count++;
  end

endmodule

bind mcu_stream_top mcu_stream_sva stream_sva_i (
  .clk       (clk),
  .rst       (rst),
  .out_beat  (out_beat),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .done      (done),
  .error     (error),
  .busy      (busy)
);

// ==== tb_mcu_stream.sv ====
module tb_mcu_stream;
  timeunit 1ns;
  timeprecision 1ps;

  import mcu_ctrl_pkg::*;
  import mcu_stream_pkg::*;

  localparam int ADDR_WIDTH = 6;

  // One line of the stimulus file
  typedef struct packed {
    logic        is_job;
    logic [15:0] f0;
    logic [15:0] f1;
    logic [15:0] f2;
    logic        rand_ready;
  } cmd_t;

  logic         clk;
  logic         rst;
  bram_wr_t     wr;
  logic         start;
  mcu_limits_t  limits;
  stream_beat_t out_beat;
  logic         out_valid;
  logic         out_ready;
  logic         done;
  logic         error;
  logic         busy;

  logic [DATA_WIDTH-1:0] ref_mem [2**ADDR_WIDTH];
  cmd_t                  cmd_q[$];
  integer                seed;
  int                    cycle_cnt;
  int                    cycle_limit;

  mcu_stream_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .BRAM_ACK   (1'b1)
  ) dut_i (
    .clk       (clk),
    .rst       (rst),
    .wr        (wr),
    .start     (start),
    .limits    (limits),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .done      (done),
    .error     (error),
    .busy      (busy)
  );

  always #50 clk = ~clk;

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic abort_with(input string msg);
    $display("At %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_beat(input stream_beat_t act, input stream_beat_t exp);
    if (act !== exp) begin
      $display("FAILED %0t: beat data %h last %b, expected data %h last %b",
               $time, act.data, act.last, exp.data, exp.last);
      stop_run();
    end
  endtask

  task automatic check_status(input logic act_done, input logic act_error,
                              input logic act_busy, input logic exp_done,
                              input logic exp_error, input logic exp_busy);
    if ({act_done, act_error, act_busy} !== {exp_done, exp_error, exp_busy}) begin
      $display("FAILED %0t: done error busy = %b %b %b, expected %b %b %b",
               $time, act_done, act_error, act_busy, exp_done, exp_error, exp_busy);
      stop_run();
    end
  endtask

  // Cycle budget from the job sizes in the stimulus file
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Run went past its limit of %0d cycles", cycle_limit);
      stop_run();
    end
  end

  always @(negedge clk) begin
    if (dut_i.stream_sva_i.fail_count != 0) begin
      $display("A bound assertion on the stream ports failed");
      stop_run();
    end
  end

  task automatic read_stimulus();
    int          fd;
    int          c;
    int          code;
    int          mode;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] d;
    cmd_t        cmd;
    fd = $fopen("mcu_stream_stimulus.txt", "r");
    if (fd == 0) begin
      abort_with("The stimulus file mcu_stream_stimulus.txt could not be opened");
    end
    c = $fgetc(fd);
    while (c != -1) begin
      cmd = '0;
      if (c == "#") begin
        while (c != "\n" && c != -1) begin
          c = $fgetc(fd);
        end
      end else if (c == "W") begin
        code = $fscanf(fd, "%h %h", a, b);
        if (code != 2) begin
          abort_with("A W line in the stimulus file is malformed");
        end
        cmd.f0 = a;
        cmd.f1 = b;
        cmd_q.push_back(cmd);
      end else if (c == "J") begin
        code = $fscanf(fd, "%d %d %d %d", a, b, d, mode);
        if (code != 4) begin
          abort_with("A J line in the stimulus file is malformed");
        end
        cmd.is_job     = 1'b1;
        cmd.f0         = a;
        cmd.f1         = b;
        cmd.f2         = d;
        cmd.rand_ready = mode[0];
        cmd_q.push_back(cmd);
        cycle_limit += int'(a) * int'(b) * int'(d) * 8 + 50;
      end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
        abort_with("The stimulus file holds an unknown line kind");
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
    cycle_limit += 200;
  endtask

  task automatic drive_ready(input logic rand_ready);
    int rnd;
    if (rand_ready) begin
      rnd       = $random(seed);
      out_ready = rnd[0];
    end else begin
      out_ready = 1'b1;
    end
  endtask

  task automatic step_cycle(input logic rand_ready);
    @(posedge clk);
    #1;
    start = 1'b0;
    wr.en = 1'b0;
    drive_ready(rand_ready);
    // Sample half a period later, outputs are settled by then
    @(negedge clk);
  endtask

  task automatic load_word(input cmd_t cmd);
    @(posedge clk);
    #1;
    wr.en   = 1'b1;
    wr.addr = cmd.f0;
    wr.data = cmd.f1;
    ref_mem[cmd.f0[ADDR_WIDTH-1:0]] = cmd.f1;
  endtask

  task automatic run_job(input cmd_t cmd);
    stream_beat_t exp_q[$];
    stream_beat_t exp_beat;
    int           p;
    int           a;
    int           r;
    int           k;
    int           fin;
    logic         zero_job;
    // Pass, then address, then repeat of the same word
    for (p = 0; p < int'(cmd.f1); p++) begin
      for (a = 0; a < int'(cmd.f0); a++) begin
        for (r = 0; r < int'(cmd.f2); r++) begin
          exp_beat.data = ref_mem[a];
          exp_beat.last = (p == int'(cmd.f1) - 1) && (a == int'(cmd.f0) - 1) &&
                          (r == int'(cmd.f2) - 1);
          exp_q.push_back(exp_beat);
        end
      end
    end
    zero_job = (cmd.f0 == 0) || (cmd.f1 == 0) || (cmd.f2 == 0);
    @(posedge clk);
    #1;
    wr.en  = 1'b0;
    limits = '{addr_max: cmd.f0, inter_max: cmd.f1, intra_max: cmd.f2};
    start  = 1'b1;
    drive_ready(cmd.rand_ready);
    @(negedge clk);
    if (zero_job) begin
      for (k = 0; k <= 4; k++) begin
        if (k > 0) begin
          step_cycle(cmd.rand_ready);
        end
        if (out_valid) begin
          abort_with("A valid beat appeared during a job with a zero limit");
        end
        if (k == 3 && !error) begin
          abort_with("No error pulse arrived three cycles after start");
        end
        check_status(done, error, busy, 1'b0, k == 3, k >= 1 && k <= 3);
      end
    end else begin
      k   = 0;
      fin = -1;
      // fin marks the cycle of the final transfer
      while (fin < 0 || k <= fin + 3) begin
        if (k > 0) begin
          step_cycle(cmd.rand_ready);
        end
        if (k < 3 && out_valid) begin
          abort_with("A valid beat appeared before the first read could return");
        end
        if (k == 3 && !out_valid) begin
          abort_with("No valid beat three cycles after start");
        end
        if (fin >= 0 && out_valid) begin
          abort_with("A valid beat appeared after the final beat");
        end
        if (fin >= 0 && k == fin + 2 && !done) begin
          abort_with("No done pulse two cycles after the final beat");
        end
        check_status(done, error, busy, fin >= 0 && k == fin + 2, 1'b0,
                     k >= 1 && !(fin >= 0 && k == fin + 3));
        if (fin < 0 && out_valid && out_ready) begin
          exp_beat = exp_q.pop_front();
          check_beat(out_beat, exp_beat);
          if (exp_q.size() == 0) begin
            fin = k;
          end
        end
        k++;
      end
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    wr          = '0;
    start       = 1'b0;
    limits      = '0;
    out_ready   = 1'b0;
    seed        = 32'hed1f799b;
    cycle_cnt   = 0;
    cycle_limit = 0;
    read_stimulus();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (cmd_q[i]) begin
      if (cmd_q[i].is_job) begin
        run_job(cmd_q[i]);
      end else begin
        load_word(cmd_q[i]);
      end
    end
    step_cycle(1'b0);
    if (dut_i.stream_sva_i.fail_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Bound assertion failures were recorded");
      stop_run();
    end
  end

endmodule

// ==== mcu_stream_stimulus.txt ====
# Columns of W lines are kind, BRAM address and data word, both in hex
# Columns of J lines are kind, addr_max, inter_max, intra_max and ready mode in decimal
# Ready mode 0 keeps out_ready high and mode 1 draws it at random
# BRAM contents
W 00 a001
W 01 b112
W 02 c223
W 03 d334
W 04 e445
W 05 f556
W 06 0667
W 07 1778
# Single pass
J 8 1 1 0
# Three passes
J 5 3 1 0
# Four repeats
J 6 1 4 0
# Random back-pressure
J 6 1 4 1
# Zero limit then a good job
J 4 2 0 0
J 7 2 2 1
# Rewritten words, address 43 lands on 03
W 43 5a5a
W 05 a5a5
J 8 2 3 1

// ==== mcu_stream.f ====
mcu_ctrl_pkg.sv
mcu_stream_pkg.sv
data_bram.sv
axis_skid_buffer.sv
mcu_global_fsm.sv
mcu_local_bram_fsm.sv
mcu_stream_top.sv
mcu_stream_sva.sv
tb_mcu_stream.sv
